// File: sim/vi_core_testdata.txt
# test <name> <1 if a control write is tried while busy>
# i <instruction hex> <expected pc hex> <expected rd decimal> <expected value hex>
# run <instruction count>
test alu_indep 0
i 00500093 00000000 1 00000005
i FFD00113 00000004 2 FFFFFFFD
i 0F006193 00000008 3 000000F0
i 7FF04213 0000000C 4 000007FF
i 0FF07293 00000010 5 00000000
i 00102313 00000014 6 00000001
i 00103393 00000018 7 00000001
i 00208433 0000001C 8 00000002
i 0041C4B3 00000020 9 0000070F
run 9
test forwarding 1
i 00700513 00000000 10 00000007
i 00150513 00000004 10 00000008
i 00A505B3 00000008 11 00000010
i 40A58633 0000000C 12 00000008
i 000566B3 00000010 13 00000008
i 00D60733 00000014 14 00000010
i 00271793 00000018 15 00000040
i FC078513 0000001C 10 00000000
run 8
test signed_shift 0
i FFF00093 00000000 1 FFFFFFFF
i 00100113 00000004 2 00000001
i 0020A1B3 00000008 3 00000001
i 0020B233 0000000C 4 00000000
i 4040D293 00000010 5 FFFFFFFF
i 0040D313 00000014 6 0FFFFFFF
i 01F11393 00000018 7 80000000
i 40238433 0000001C 8 7FFFFFFF
i 4023D4B3 00000020 9 C0000000
i FFF13513 00000024 10 00000001
run 10
test x0_ctrl 1
i 00900013 00000000 0 00000000
i 00108033 00000004 0 00000000
i 000065B3 00000008 11 00000000
i 00300613 0000000C 12 00000003
i 00C006B3 00000010 13 00000003
i 0000007F 00000014 0 00000000
run 6

// File: vi_core.f
common/vi_pkg.sv
src/fetch.sv
decode/decoder.sv
decode/int_registers.sv
decode/bypass_ctrl.sv
src/int_alu.sv
src/vi_core.sv
sim/clock_gen.sv
sim/vi_core_assertions.sv
sim/vi_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds vi_core_tb with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vi_core_tb \
	-f vi_core.f -o vi_core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/vi_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Everything OK" sim.log; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// File: sim/vi_core_tb.sv
// testbench for vi_core, loads programs over APB and checks the retire stream from the data file
module vi_core_tb;

	logic clk;
	logic reset;
	logic [vi_pkg::APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [vi_pkg::XLEN-1:0] pwdata;
	logic [vi_pkg::XLEN-1:0] prdata;
	logic pready;
	logic pslverr;
	logic retire_valid;
	logic [vi_pkg::XLEN-1:0] retire_pc;
	logic [vi_pkg::REG_ADDR_W-1:0] retire_rd;
	logic [vi_pkg::XLEN-1:0] retire_value;

	integer seed;
	bit run_open;
	string cur_test;

	// parsed tests, instruction records live in flat queues
	string tname[$];
	int first_q[$];
	int len_q[$];
	int run_q[$];
	bit busy_chk_q[$];
	logic [vi_pkg::XLEN-1:0] word_q[$];
	logic [vi_pkg::XLEN-1:0] exp_pc_q[$];
	logic [vi_pkg::REG_ADDR_W-1:0] exp_rd_q[$];
	logic [vi_pkg::XLEN-1:0] exp_val_q[$];

	clock_gen clock_gen_i (
		.clk_o (clk),
		.reset_o (reset)
	);

	vi_core dut_i (
		.clk_i (clk),
		.reset_i (reset),
		.paddr_i (paddr),
		.psel_i (psel),
		.penable_i (penable),
		.pwrite_i (pwrite),
		.pwdata_i (pwdata),
		.prdata_o (prdata),
		.pready_o (pready),
		.pslverr_o (pslverr),
		.retire_valid_o (retire_valid),
		.retire_pc_o (retire_pc),
		.retire_rd_o (retire_rd),
		.retire_value_o (retire_value)
	);

	task automatic check_word(input string what, input logic [vi_pkg::XLEN-1:0] exp,
		input logic [vi_pkg::XLEN-1:0] act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
			$display("Something failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_rd(input string what, input logic [vi_pkg::REG_ADDR_W-1:0] exp,
		input logic [vi_pkg::REG_ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			$display("Something failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
			$display("Something failed");
			$fatal(1, "mismatch");
		end
	endtask

	// one APB transfer after 0 to 3 idle cycles, outputs sampled inside the access phase
	task automatic apb_xfer(input logic [vi_pkg::APB_ADDR_W-1:0] addr, input logic write,
		input logic [vi_pkg::XLEN-1:0] wdata, output logic [vi_pkg::XLEN-1:0] rdata,
		output logic err);
		int idle;
		idle = $random(seed) & 3;
		repeat (idle) @(negedge clk);
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#2;
		rdata = prdata;
		err = pslverr;
		check_flag("pready", 1'b1, pready);
		if (!run_open) begin
			check_flag("retire while idle", 1'b0, retire_valid);
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// entered on the first falling edge after the control access phase
	task automatic watch_retires(input int t);
		int s;
		s = first_q[t];
		repeat (3) begin
			check_flag("retire before start", 1'b0, retire_valid);
			@(negedge clk);
		end
		for (int j = 0; j < run_q[t]; j++) begin
			check_flag("retire valid", 1'b1, retire_valid);
			check_word("retire pc", exp_pc_q[s+j], retire_pc);
			check_rd("retire rd", exp_rd_q[s+j], retire_rd);
			check_word("retire value", exp_val_q[s+j], retire_value);
			@(negedge clk);
		end
		repeat (3) begin
			check_flag("retire after end", 1'b0, retire_valid);
			@(negedge clk);
		end
	endtask

	// reads busy until it drops, it must stay high up to the cycle of the last retire
	task automatic poll_busy(input int t, input time t0);
		logic [vi_pkg::XLEN-1:0] rdata;
		logic err;
		longint cyc;
		do begin
			apb_xfer(vi_pkg::CTRL_ADDR, 1'b0, '0, rdata, err);
			// cycles from the start access phase to this access phase
			cyc = longint'(($time - t0) / 10);
			check_flag("ctrl read pslverr", 1'b0, err);
			// last retire lands N+3 cycles after the start access
			check_flag("busy", cyc <= longint'(run_q[t] + 3), rdata[0]);
		end while (rdata[0] === 1'b1);
	endtask

	task automatic run_test(input int t);
		logic [vi_pkg::XLEN-1:0] rdata;
		logic err;
		logic [vi_pkg::XLEN-1:0] rdata2;
		logic err2;
		time t0;
		cur_test = tname[t];
		for (int j = 0; j < len_q[t]; j++) begin
			apb_xfer(vi_pkg::APB_ADDR_W'(4 * j), 1'b1, word_q[first_q[t]+j], rdata, err);
			check_flag("imem write pslverr", 1'b0, err);
		end
		for (int j = 0; j < len_q[t]; j++) begin
			apb_xfer(vi_pkg::APB_ADDR_W'(4 * j), 1'b0, '0, rdata, err);
			check_flag("imem read pslverr", 1'b0, err);
			check_word("imem readback", word_q[first_q[t]+j], rdata);
		end
		apb_xfer(vi_pkg::CTRL_ADDR, 1'b1, vi_pkg::XLEN'(run_q[t]), rdata, err);
		t0 = $time;
		check_flag("start pslverr", 1'b0, err);
		run_open = 1'b1;
		fork
			watch_retires(t);
			begin
				if (busy_chk_q[t]) begin
					apb_xfer(vi_pkg::CTRL_ADDR, 1'b1, 32'd5, rdata2, err2);
					check_flag("control write while busy", 1'b1, err2);
				end
				poll_busy(t, t0);
			end
		join
		run_open = 1'b0;
	endtask

	initial begin
		int fd;
		int xfers;
		longint limit;
		string line;
		string kw;
		string name;
		int bflag;
		int n;
		logic [vi_pkg::XLEN-1:0] w;
		logic [vi_pkg::XLEN-1:0] pc;
		logic [vi_pkg::REG_ADDR_W-1:0] rd;
		logic [vi_pkg::XLEN-1:0] val;
		logic [vi_pkg::XLEN-1:0] rdata;
		logic err;
		seed = 32'h3688_0ad9;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		run_open = 1'b0;
		cur_test = "reset";
		fd = $fopen("sim/vi_core_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			$display("Something failed");
			$fatal(1, "no data");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			void'($sscanf(line, "%s", kw));
			if (kw == "test") begin
				void'($sscanf(line, "%s %s %d", kw, name, bflag));
				tname.push_back(name);
				busy_chk_q.push_back(bflag != 0);
				first_q.push_back(word_q.size());
				len_q.push_back(0);
			end else if (kw == "i") begin
				void'($sscanf(line, "%s %h %h %d %h", kw, w, pc, rd, val));
				word_q.push_back(w);
				exp_pc_q.push_back(pc);
				exp_rd_q.push_back(rd);
				exp_val_q.push_back(val);
				len_q[len_q.size()-1] = len_q[len_q.size()-1] + 1;
			end else if (kw == "run") begin
				void'($sscanf(line, "%s %d", kw, n));
				run_q.push_back(n);
			end
		end
		$fclose(fd);

		// map checks plus per test loads, readbacks, start, busy write and final poll
		xfers = 3;
		for (int t = 0; t < tname.size(); t++) begin
			xfers += 2 * len_q[t] + 3;
		end
		limit = (20 * longint'(exp_pc_q.size()) + 50 * longint'(xfers)) * 10;
		fork
			begin
				#(limit);
				$display("run timed out after %0d time units", limit);
				$display("Something failed");
				$fatal(1, "timeout");
			end
		join_none

		while (reset !== 1'b0) @(negedge clk);
		cur_test = "apb_map";
		apb_xfer(vi_pkg::CTRL_ADDR, 1'b0, '0, rdata, err);
		check_flag("ctrl read pslverr", 1'b0, err);
		check_word("busy after reset", '0, rdata);
		apb_xfer(12'h104, 1'b1, 32'h1234_5678, rdata, err);
		check_flag("write 0x104 pslverr", 1'b1, err);
		apb_xfer(12'h104, 1'b0, '0, rdata, err);
		check_flag("read 0x104 pslverr", 1'b1, err);

		for (int t = 0; t < tname.size(); t++) begin
			run_test(t);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: sim/vi_core_assertions.sv
// concurrent checks on the vi_core ports, bound into every vi_core instance
module vi_core_assertions (
	input logic clk_i,
	input logic reset_i,
	input logic psel_i,
	input logic penable_i,
	input logic pready_o,
	input logic pslverr_o,
	input logic retire_valid_o,
	input logic [vi_pkg::REG_ADDR_W-1:0] retire_rd_o,
	input logic [vi_pkg::XLEN-1:0] retire_value_o
);

	// no wait states on the APB port
	a_pready_high: assert property (@(posedge clk_i) disable iff (reset_i) pready_o)
		else $error("pready_o dropped low");

	// x0 destinations never carry a value
	a_rd_zero_value: assert property (@(posedge clk_i) disable iff (reset_i)
		(retire_valid_o && retire_rd_o == '0) |-> (retire_value_o == '0))
		else $error("retire to x0 with nonzero value");

	a_retire_after_reset: assert property (@(posedge clk_i) reset_i |=> !retire_valid_o)
		else $error("retire_valid_o high right after reset");

	// errors only in the access phase
	a_slverr_access: assert property (@(posedge clk_i) disable iff (reset_i)
		pslverr_o |-> (psel_i && penable_i))
		else $error("pslverr_o outside an access phase");

endmodule

bind vi_core vi_core_assertions vi_core_assertions_i (
	.clk_i (clk_i),
	.reset_i (reset_i),
	.psel_i (psel_i),
	.penable_i (penable_i),
	.pready_o (pready_o),
	.pslverr_o (pslverr_o),
	.retire_valid_o (retire_valid_o),
	.retire_rd_o (retire_rd_o),
	.retire_value_o (retire_value_o)
);

// File: sim/clock_gen.sv
// testbench clock and reset source, 10 unit period with reset held for the first 8 cycles
module clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (8) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// File: src/vi_core.sv
// top level of the four stage integer pipeline, program loaded over APB
module vi_core (
	input logic clk_i,
	input logic reset_i,
	input logic [vi_pkg::APB_ADDR_W-1:0] paddr_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [vi_pkg::XLEN-1:0] pwdata_i,
	output logic [vi_pkg::XLEN-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic retire_valid_o,
	output logic [vi_pkg::XLEN-1:0] retire_pc_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] retire_rd_o,
	output logic [vi_pkg::XLEN-1:0] retire_value_o
);

	// fetch to decode
	logic dec_valid;
	vi_pkg::instr_u dec_instr;
	logic [vi_pkg::XLEN-1:0] dec_pc;

	// decode operands
	logic [vi_pkg::REG_ADDR_W-1:0] rs1;
	logic [vi_pkg::REG_ADDR_W-1:0] rs2;
	logic [vi_pkg::XLEN-1:0] reg_a;
	logic [vi_pkg::XLEN-1:0] reg_b;
	logic [vi_pkg::XLEN-1:0] op_a;
	logic [vi_pkg::XLEN-1:0] op_b;

	// decode to execute
	logic exe_valid;
	logic [vi_pkg::ALU_OP_W-1:0] exe_alu_op;
	logic [vi_pkg::XLEN-1:0] exe_a;
	logic [vi_pkg::XLEN-1:0] exe_b;
	logic [vi_pkg::REG_ADDR_W-1:0] exe_rd;
	logic [vi_pkg::XLEN-1:0] exe_pc;
	logic [vi_pkg::XLEN-1:0] exe_result;

	fetch fetch (
		.clk_i (clk_i),
		.reset_i (reset_i),
		.paddr_i (paddr_i),
		.psel_i (psel_i),
		.penable_i (penable_i),
		.pwrite_i (pwrite_i),
		.pwdata_i (pwdata_i),
		.prdata_o (prdata_o),
		.pready_o (pready_o),
		.pslverr_o (pslverr_o),
		.dec_valid_o (dec_valid),
		.dec_instr_o (dec_instr),
		.dec_pc_o (dec_pc)
	);

	decoder decoder (
		.clk_i (clk_i),
		.reset_i (reset_i),
		.dec_valid_i (dec_valid),
		.dec_instr_i (dec_instr),
		.dec_pc_i (dec_pc),
		.rs1_o (rs1),
		.rs2_o (rs2),
		.op_a_i (op_a),
		.op_b_i (op_b),
		.exe_valid_o (exe_valid),
		.exe_alu_op_o (exe_alu_op),
		.exe_a_o (exe_a),
		.exe_b_o (exe_b),
		.exe_rd_o (exe_rd),
		.exe_pc_o (exe_pc)
	);

	// written from the retire record
	int_registers int_registers (
		.clk_i (clk_i),
		.reset_i (reset_i),
		.rs1_i (rs1),
		.rs2_i (rs2),
		.rd_a_o (reg_a),
		.rd_b_o (reg_b),
		.wr_en_i (retire_valid_o),
		.wr_addr_i (retire_rd_o),
		.wr_data_i (retire_value_o)
	);

	bypass_ctrl bypass_ctrl (
		.rs1_i (rs1),
		.rs2_i (rs2),
		.reg_a_i (reg_a),
		.reg_b_i (reg_b),
		.exe_valid_i (exe_valid),
		.exe_rd_i (exe_rd),
		.exe_result_i (exe_result),
		.wb_valid_i (retire_valid_o),
		.wb_rd_i (retire_rd_o),
		.wb_value_i (retire_value_o),
		.op_a_o (op_a),
		.op_b_o (op_b)
	);

	int_alu int_alu (
		.clk_i (clk_i),
		.reset_i (reset_i),
		.exe_valid_i (exe_valid),
		.exe_alu_op_i (exe_alu_op),
		.exe_a_i (exe_a),
		.exe_b_i (exe_b),
		.exe_rd_i (exe_rd),
		.exe_pc_i (exe_pc),
		.exe_result_o (exe_result),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o (retire_pc_o),
		.retire_rd_o (retire_rd_o),
		.retire_value_o (retire_value_o)
	);

endmodule

// File: src/int_alu.sv
// execute stage ALU and the register holding the retire record
module int_alu (
	input logic clk_i,
	input logic reset_i,
	input logic exe_valid_i,
	input logic [vi_pkg::ALU_OP_W-1:0] exe_alu_op_i,
	input logic [vi_pkg::XLEN-1:0] exe_a_i,
	input logic [vi_pkg::XLEN-1:0] exe_b_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] exe_rd_i,
	input logic [vi_pkg::XLEN-1:0] exe_pc_i,
	output logic [vi_pkg::XLEN-1:0] exe_result_o,
	output logic retire_valid_o,
	output logic [vi_pkg::XLEN-1:0] retire_pc_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] retire_rd_o,
	output logic [vi_pkg::XLEN-1:0] retire_value_o
);

	logic [vi_pkg::SHAMT_W-1:0] shamt;

	assign shamt = exe_b_i[vi_pkg::SHAMT_W-1:0];

	always_comb begin
		exe_result_o = '0;
		case (exe_alu_op_i)
			vi_pkg::ALU_ADD: exe_result_o = exe_a_i + exe_b_i;
			vi_pkg::ALU_SUB: exe_result_o = exe_a_i - exe_b_i;
			vi_pkg::ALU_SLL: exe_result_o = exe_a_i << shamt;
			vi_pkg::ALU_SLT: exe_result_o[0] = $signed(exe_a_i) < $signed(exe_b_i);
			vi_pkg::ALU_SLTU: exe_result_o[0] = exe_a_i < exe_b_i;
			vi_pkg::ALU_XOR: exe_result_o = exe_a_i ^ exe_b_i;
			vi_pkg::ALU_SRL: exe_result_o = exe_a_i >> shamt;
			vi_pkg::ALU_SRA: exe_result_o = $unsigned($signed(exe_a_i) >>> shamt);
			vi_pkg::ALU_OR: exe_result_o = exe_a_i | exe_b_i;
			vi_pkg::ALU_AND: exe_result_o = exe_a_i & exe_b_i;
			default: exe_result_o = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			retire_valid_o <= 1'b0;
		end else begin
			retire_valid_o <= exe_valid_i;
		end
	end

	// x0 destinations retire as zero
	always_ff @(posedge clk_i) begin
		retire_pc_o <= exe_pc_i;
		retire_rd_o <= exe_rd_i;
		retire_value_o <= (exe_rd_i == '0) ? '0 : exe_result_o;
	end

endmodule

// File: decode/bypass_ctrl.sv
// operand forwarding for decode, newest of execute, retire and register file wins
module bypass_ctrl (
	input logic [vi_pkg::REG_ADDR_W-1:0] rs1_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] rs2_i,
	input logic [vi_pkg::XLEN-1:0] reg_a_i,
	input logic [vi_pkg::XLEN-1:0] reg_b_i,
	input logic exe_valid_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] exe_rd_i,
	input logic [vi_pkg::XLEN-1:0] exe_result_i,
	input logic wb_valid_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input logic [vi_pkg::XLEN-1:0] wb_value_i,
	output logic [vi_pkg::XLEN-1:0] op_a_o,
	output logic [vi_pkg::XLEN-1:0] op_b_o
);

	logic exe_live;
	logic wb_live;
	logic a_exe_hit;
	logic a_wb_hit;
	logic b_exe_hit;
	logic b_wb_hit;

	// x0 is never forwarded
	assign exe_live = exe_valid_i && (exe_rd_i != '0);
	assign wb_live = wb_valid_i && (wb_rd_i != '0);

	assign a_exe_hit = exe_live && (exe_rd_i == rs1_i);
	assign a_wb_hit = wb_live && (wb_rd_i == rs1_i);
	assign b_exe_hit = exe_live && (exe_rd_i == rs2_i);
	assign b_wb_hit = wb_live && (wb_rd_i == rs2_i);

	always_comb begin
		if (a_exe_hit) begin
			op_a_o = exe_result_i;
		end else if (a_wb_hit) begin
			op_a_o = wb_value_i;
		end else begin
			op_a_o = reg_a_i;
		end
	end

	always_comb begin
		if (b_exe_hit) begin
			op_b_o = exe_result_i;
		end else if (b_wb_hit) begin
			op_b_o = wb_value_i;
		end else begin
			op_b_o = reg_b_i;
		end
	end

endmodule

// File: decode/int_registers.sv
// integer register file, two combinational reads and one write from retire
module int_registers (
	input logic clk_i,
	input logic reset_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] rs1_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] rs2_i,
	output logic [vi_pkg::XLEN-1:0] rd_a_o,
	output logic [vi_pkg::XLEN-1:0] rd_b_o,
	input logic wr_en_i,
	input logic [vi_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input logic [vi_pkg::XLEN-1:0] wr_data_i
);

	// x1 to x31, x0 has no storage
	logic [vi_pkg::XLEN-1:0] regs [1:31];

	always_comb begin
		if (rs1_i == '0) begin
			rd_a_o = '0;
		end else begin
			rd_a_o = regs[rs1_i];
		end
	end

	always_comb begin
		if (rs2_i == '0) begin
			rd_b_o = '0;
		end else begin
			rd_b_o = regs[rs2_i];
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

// File: decode/decoder.sv
// decode stage, splits the instruction word and registers the operands into execute
module decoder (
	input logic clk_i,
	input logic reset_i,
	input logic dec_valid_i,
	input vi_pkg::instr_u dec_instr_i,
	input logic [vi_pkg::XLEN-1:0] dec_pc_i,
	output logic [vi_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] rs2_o,
	input logic [vi_pkg::XLEN-1:0] op_a_i,
	input logic [vi_pkg::XLEN-1:0] op_b_i,
	output logic exe_valid_o,
	output logic [vi_pkg::ALU_OP_W-1:0] exe_alu_op_o,
	output logic [vi_pkg::XLEN-1:0] exe_a_o,
	output logic [vi_pkg::XLEN-1:0] exe_b_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] exe_rd_o,
	output logic [vi_pkg::XLEN-1:0] exe_pc_o
);

	logic [vi_pkg::ALU_OP_W-1:0] alu_op;
	logic [vi_pkg::XLEN-1:0] imm;
	logic [vi_pkg::REG_ADDR_W-1:0] rd;
	logic [2:0] funct3;
	logic alt;
	logic use_imm;

	// rs1 sits at the same place in both formats
	assign rs1_o = dec_instr_i.r.rs1;
	assign rs2_o = dec_instr_i.r.rs2;

	always_comb begin
		rd = '0;
		imm = '0;
		use_imm = 1'b0;
		alt = 1'b0;
		funct3 = dec_instr_i.r.funct3;
		case (dec_instr_i.r.opcode)
			vi_pkg::OPC_OP: begin
				rd = dec_instr_i.r.rd;
				alt = dec_instr_i.r.funct7[5];
			end
			vi_pkg::OPC_OP_IMM: begin
				rd = dec_instr_i.i.rd;
				use_imm = 1'b1;
				imm = {{(vi_pkg::XLEN-12){dec_instr_i.i.imm[11]}}, dec_instr_i.i.imm};
				if (funct3 == vi_pkg::F3_SLL || funct3 == vi_pkg::F3_SRL_SRA) begin
					// shamt only, bit 10 picks srai
					imm = {{(vi_pkg::XLEN-vi_pkg::SHAMT_W){1'b0}},
						dec_instr_i.i.imm[vi_pkg::SHAMT_W-1:0]};
					alt = dec_instr_i.i.imm[10];
				end
			end
			default: begin
				// unsupported opcode, retires with rd 0
				rd = '0;
			end
		endcase
	end

	always_comb begin
		case (funct3)
			vi_pkg::F3_ADD_SUB: alu_op = (alt && !use_imm) ? vi_pkg::ALU_SUB : vi_pkg::ALU_ADD;
			vi_pkg::F3_SLL: alu_op = vi_pkg::ALU_SLL;
			vi_pkg::F3_SLT: alu_op = vi_pkg::ALU_SLT;
			vi_pkg::F3_SLTU: alu_op = vi_pkg::ALU_SLTU;
			vi_pkg::F3_XOR: alu_op = vi_pkg::ALU_XOR;
			vi_pkg::F3_SRL_SRA: alu_op = alt ? vi_pkg::ALU_SRA : vi_pkg::ALU_SRL;
			vi_pkg::F3_OR: alu_op = vi_pkg::ALU_OR;
			default: alu_op = vi_pkg::ALU_AND;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			exe_valid_o <= 1'b0;
		end else begin
			exe_valid_o <= dec_valid_i;
		end
	end

	// decode/execute latch payload
	always_ff @(posedge clk_i) begin
		exe_alu_op_o <= alu_op;
		exe_a_o <= op_a_i;
		exe_b_o <= use_imm ? imm : op_b_i;
		exe_rd_o <= rd;
		exe_pc_o <= dec_pc_i;
	end

endmodule

// File: src/fetch.sv
// fetch stage with the APB program port, run counter, pc and the register into decode
module fetch (
	input logic clk_i,
	input logic reset_i,
	input logic [vi_pkg::APB_ADDR_W-1:0] paddr_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [vi_pkg::XLEN-1:0] pwdata_i,
	output logic [vi_pkg::XLEN-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic dec_valid_o,
	output vi_pkg::instr_u dec_instr_o,
	output logic [vi_pkg::XLEN-1:0] dec_pc_o
);

	logic [vi_pkg::XLEN-1:0] imem [vi_pkg::IMEM_DEPTH];
	logic [vi_pkg::RUN_CNT_W-1:0] cnt_q;
	logic [vi_pkg::XLEN-1:0] pc_q;
	logic [1:0] trail_q;
	logic access;
	logic imem_hit;
	logic ctrl_hit;
	logic busy;
	logic fetching;
	logic ctrl_wr_ok;

	assign access = psel_i && penable_i;
	assign imem_hit = (paddr_i[vi_pkg::APB_ADDR_W-1:vi_pkg::IMEM_ADDR_W+2] == '0) &&
		(paddr_i[1:0] == 2'b00);
	assign ctrl_hit = (paddr_i == vi_pkg::CTRL_ADDR);

	// busy until the last issued instruction has left retire
	assign fetching = (cnt_q != '0);
	assign busy = fetching || dec_valid_o || (trail_q != 2'b00);

	assign ctrl_wr_ok = access && ctrl_hit && pwrite_i && !busy;
	assign pready_o = 1'b1;
	assign pslverr_o = access && !(imem_hit || (ctrl_hit && !(pwrite_i && busy)));

	always_comb begin
		prdata_o = '0;
		if (ctrl_hit) begin
			prdata_o[0] = busy;
		end else if (imem_hit) begin
			prdata_o = imem[paddr_i[vi_pkg::IMEM_ADDR_W+1:2]];
		end
	end

	always_ff @(posedge clk_i) begin
		if (access && pwrite_i && imem_hit) begin
			imem[paddr_i[vi_pkg::IMEM_ADDR_W+1:2]] <= pwdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cnt_q <= '0;
			pc_q <= '0;
			dec_valid_o <= 1'b0;
			trail_q <= 2'b00;
		end else begin
			dec_valid_o <= fetching;
			trail_q <= {trail_q[0], dec_valid_o};
			if (ctrl_wr_ok) begin
				cnt_q <= pwdata_i[vi_pkg::RUN_CNT_W-1:0];
				pc_q <= '0;
			end else if (fetching) begin
				cnt_q <= cnt_q - 1'b1;
				pc_q <= pc_q + vi_pkg::XLEN'(4);
			end
		end
	end

	// fetch/decode latch payload
	always_ff @(posedge clk_i) begin
		dec_instr_o <= imem[pc_q[vi_pkg::IMEM_ADDR_W+1:2]];
		dec_pc_o <= pc_q;
	end

endmodule

// File: common/vi_pkg.sv
// sizes, opcodes, ALU codes, APB map and instruction formats shared by every vi_core stage
package vi_pkg;

	// datapath and register file
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W = 5;

	// instruction memory, one word per entry
	localparam int IMEM_DEPTH = 64;
	localparam int IMEM_ADDR_W = 6;

	// APB map, words 0x000 to 0x0fc are instruction memory
	localparam int APB_ADDR_W = 12;
	localparam logic [APB_ADDR_W-1:0] CTRL_ADDR = 12'h100;
	localparam int RUN_CNT_W = 7;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3 encodings of the integer ALU group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd9;

	// one instruction word, seen as R-format or as I-format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} i;
	} instr_u;

endpackage
